//--- all.f
src/fifo_pkg.sv
src/fifo_write_port.sv
src/fifo_occupancy.sv
src/fifo_ram.sv
src/fifo_read_port.sv
src/sync_fifo_top.sv
tests/sync_fifo_sva.sv
tests/sync_fifo_tb.sv

//--- Makefile
# Verilator build and run of the sync fifo testbench

SRCS := $(wildcard src/*.sv tests/*.sv)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/Vsync_fifo_tb: $(SRCS) all.f
	verilator --binary --timing --assert -j 0 --top-module sync_fifo_tb -f all.f

# pass only if the log holds the pass line
run: obj_dir/Vsync_fifo_tb
	./obj_dir/Vsync_fifo_tb 2>&1 | tee sim.log
	grep -q '\*\*\* TEST PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log

//--- tests/sync_fifo_tb.sv
// sync fifo testbench
// fills to full, writes into a full fifo, drains to empty, reads an
// empty fifo, then runs a random mix of reads and writes across the
// address wrap. read data is checked against the write order here,
// flag, level, strobe and error rules by the bound assertion module

module sync_fifo_tb
   import fifo_pkg::*;
();

   // -------------------------------------------------------------------------
   // dut signals
   // -------------------------------------------------------------------------
   logic   pos_clk;
   logic   aresetn;
   logic   wr_en;
   data_t  wr_data;
   logic   rd_en;
   data_t  rd_data;
   logic   dvld;
   logic   wack;
   logic   overflow;
   logic   underflow;
   logic   full;
   logic   afull;
   logic   empty;
   logic   aempty;
   level_t level;

   // -------------------------------------------------------------------------
   // checker state
   // -------------------------------------------------------------------------
   data_t  exp_q[$];           // accepted words not yet read back
   data_t  exp_word;
   int     model_level;        // occupancy by the fifo rules
   int     wr_total;           // accepted writes since reset
   logic   wr_ok;
   logic   rd_ok;
   int     data_errs;
   int     timeout_errs;
   int     other_errs;
   int     assert_errs;        // failures seen by the bound checker
   integer seed;
   data_t  data_cnt;           // next write word
   string  test_name;

   // 20 unit clock
   initial pos_clk = 1'b0;
   always #10 pos_clk = ~pos_clk;

   sync_fifo_top dut0 (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .wr_en_i     (wr_en),
      .wr_data_i   (wr_data),
      .wack_o      (wack),
      .overflow_o  (overflow),
      .rd_en_i     (rd_en),
      .rd_data_o   (rd_data),
      .dvld_o      (dvld),
      .underflow_o (underflow),
      .full_o      (full),
      .afull_o     (afull),
      .empty_o     (empty),
      .aempty_o    (aempty),
      .level_o     (level)
   );

   // rule checks live in the assertion module
   bind sync_fifo_top sync_fifo_sva sva0 (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .wr_en_i     (wr_en_i),
      .rd_en_i     (rd_en_i),
      .wack_i      (wack_o),
      .dvld_i      (dvld_o),
      .overflow_i  (overflow_o),
      .underflow_i (underflow_o),
      .full_i      (full_o),
      .afull_i     (afull_o),
      .empty_i     (empty_o),
      .aempty_i    (aempty_o),
      .level_i     (level_o)
   );

   // -------------------------------------------------------------------------
   // data order monitor
   // -------------------------------------------------------------------------
   always @(posedge pos_clk) begin
      if (aresetn) begin
         if (dvld) begin                       // read from last cycle is back
            if (exp_q.size() == 0) begin
               other_errs++;
               $display("data-valid went high in %s with no word outstanding", test_name);
            end else begin
               exp_word = exp_q.pop_front();
               if (rd_data !== exp_word) begin
                  data_errs++;
                  $display("error: %s expected %h actual %h", test_name, exp_word, rd_data);
               end
            end
         end
         // acceptance from the tb's own count, not the dut flags
         wr_ok = wr_en && (model_level != FIFO_DEPTH);
         rd_ok = rd_en && (model_level != 0);
         if (wr_ok) begin
            exp_q.push_back(wr_data);
            wr_total++;
         end
         model_level = model_level + (wr_ok ? 1 : 0) - (rd_ok ? 1 : 0);
      end
   end

   // drive on the rising edge, return at the falling edge
   task automatic drive_cycle(input logic we, input logic re);
      @(posedge pos_clk);
      wr_en    <= we;
      rd_en    <= re;
      wr_data  <= data_cnt;
      data_cnt = data_cnt + data_t'(1);     // incrementing write data
      @(negedge pos_clk);
   endtask

   task automatic fill_until_full(input int max_cycles);
      int n;
      n = 0;
      while (!full && n < max_cycles) begin
         drive_cycle(1'b1, 1'b0);
         n++;
      end
      if (!full) begin
         timeout_errs++;
         $display("fifo never reported full within %0d cycles in %s", max_cycles, test_name);
      end
   endtask

   task automatic drain_until_empty(input int max_cycles);
      int n;
      n = 0;
      while (!empty && n < max_cycles) begin
         drive_cycle(1'b0, 1'b1);
         n++;
      end
      if (!empty) begin
         timeout_errs++;
         $display("fifo never reported empty within %0d cycles in %s", max_cycles, test_name);
      end
   endtask

   // idle until every accepted word has come back
   task automatic wait_returned(input int max_cycles);
      int n;
      n = 0;
      drive_cycle(1'b0, 1'b0);
      while (exp_q.size() != 0 && n < max_cycles) begin
         drive_cycle(1'b0, 1'b0);
         n++;
      end
      if (exp_q.size() != 0) begin
         timeout_errs++;
         $display("%0d words never came back in %s", exp_q.size(), test_name);
      end
   endtask

   // random enables until enough words have gone in
   task automatic random_mix(input int words, input int max_cycles);
      int n;
      int start;
      int rnd;
      n     = 0;
      start = wr_total;
      while ((wr_total - start) < words && n < max_cycles) begin
         rnd = $random(seed);
         drive_cycle(rnd[0], rnd[1]);
         n++;
      end
      if ((wr_total - start) < words) begin
         timeout_errs++;
         $display("only %0d of %0d random writes accepted in %0d cycles",
                  wr_total - start, words, max_cycles);
      end
   endtask

   // -------------------------------------------------------------------------
   // stimulus
   // -------------------------------------------------------------------------
   initial begin
      seed         = 71520;
      aresetn      = 1'b0;
      wr_en        = 1'b0;
      rd_en        = 1'b0;
      wr_data      = '0;
      data_cnt     = '0;
      model_level  = 0;
      wr_total     = 0;
      data_errs    = 0;
      timeout_errs = 0;
      other_errs   = 0;
      assert_errs  = 0;
      test_name    = "reset";

      repeat (10) @(posedge pos_clk);          // reset for 10 cycles
      aresetn <= 1'b1;
      @(negedge pos_clk);
      drive_cycle(1'b0, 1'b0);

      test_name = "fill";                      // passes afull on the way
      fill_until_full(2 * FIFO_DEPTH);
      test_name = "overflow";
      repeat (3) drive_cycle(1'b1, 1'b0);      // writes into a full fifo
      test_name = "drain";                     // passes aempty
      drain_until_empty(2 * FIFO_DEPTH);
      test_name = "underflow";
      repeat (3) drive_cycle(1'b0, 1'b1);      // reads from an empty fifo
      wait_returned(8);

      test_name = "random";                    // wraps both addresses
      random_mix(4 * FIFO_DEPTH, 1000);
      test_name = "final drain";
      drain_until_empty(2 * FIFO_DEPTH);
      wait_returned(8);

      assert_errs = dut0.sva0.assert_errs;
      $display("closing: data errors %0d, timeouts %0d, other errors %0d, assert errors %0d",
               data_errs, timeout_errs, other_errs, assert_errs);
      if (data_errs + timeout_errs + other_errs + assert_errs == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule : sync_fifo_tb

//--- tests/sync_fifo_sva.sv
// fifo assertion checker
// bound into the fifo top level. covers reset values, the level
// update, the four flag rules, the ack and data-valid strobes and
// the overflow and underflow pulses

module sync_fifo_sva
   import fifo_pkg::*;
(
   input logic   pos_clk,
   input logic   aresetn,
   input logic   wr_en_i,
   input logic   rd_en_i,
   input logic   wack_i,
   input logic   dvld_i,
   input logic   overflow_i,
   input logic   underflow_i,
   input logic   full_i,
   input logic   afull_i,
   input logic   empty_i,
   input logic   aempty_i,
   input level_t level_i
);

   // accepted pair by the port rules, from top-level pins only
   logic wr_accept;
   logic rd_accept;
   int   assert_errs = 0;      // failed assertion count

   assign wr_accept = wr_en_i && !full_i;
   assign rd_accept = rd_en_i && !empty_i;

   // -------------------------------------------------------------------------
   // reset
   // -------------------------------------------------------------------------
   a_reset_values : assert property (@(posedge pos_clk)
      $rose(aresetn) |-> (empty_i && aempty_i && !full_i && !afull_i && !wack_i && !dvld_i
                          && !overflow_i && !underflow_i && level_i == '0))
      else begin
         assert_errs++;
         $error("outputs not at their reset values after reset release");
      end

   // -------------------------------------------------------------------------
   // level and flags
   // -------------------------------------------------------------------------
   // +1, -1 or unchanged from last cycle's accepted pair
   a_level_step : assert property (@(posedge pos_clk) disable iff (!aresetn)
      level_i == $past(level_i) + level_t'($past(wr_accept)) - level_t'($past(rd_accept)))
      else begin
         assert_errs++;
         $error("level did not follow the accepted write and read");
      end

   a_full : assert property (@(posedge pos_clk) disable iff (!aresetn)
      full_i == (level_i == level_t'(FIFO_DEPTH)))
      else begin
         assert_errs++;
         $error("full flag disagrees with level");
      end

   a_empty : assert property (@(posedge pos_clk) disable iff (!aresetn)
      empty_i == (level_i == '0))
      else begin
         assert_errs++;
         $error("empty flag disagrees with level");
      end

   a_afull : assert property (@(posedge pos_clk) disable iff (!aresetn)
      afull_i == (level_i >= level_t'(AFULL_LEVEL)))
      else begin
         assert_errs++;
         $error("almost-full flag disagrees with level");
      end

   a_aempty : assert property (@(posedge pos_clk) disable iff (!aresetn)
      aempty_i == (level_i <= level_t'(AEMPTY_LEVEL)))
      else begin
         assert_errs++;
         $error("almost-empty flag disagrees with level");
      end

   // -------------------------------------------------------------------------
   // strobes and error pulses
   // -------------------------------------------------------------------------
   a_wack : assert property (@(posedge pos_clk) disable iff (!aresetn)
      wack_i == $past(wr_accept))
      else begin
         assert_errs++;
         $error("write ack not one cycle after an accepted write");
      end

   a_dvld : assert property (@(posedge pos_clk) disable iff (!aresetn)
      dvld_i == $past(rd_accept))
      else begin
         assert_errs++;
         $error("data-valid not one cycle after an accepted read");
      end

   a_overflow : assert property (@(posedge pos_clk) disable iff (!aresetn)
      overflow_i == $past(wr_en_i && full_i))
      else begin
         assert_errs++;
         $error("overflow pulse does not match a write while full");
      end

   a_underflow : assert property (@(posedge pos_clk) disable iff (!aresetn)
      underflow_i == $past(rd_en_i && empty_i))
      else begin
         assert_errs++;
         $error("underflow pulse does not match a read while empty");
      end

endmodule : sync_fifo_sva

//--- src/sync_fifo_top.sv
// single-clock fifo, top level
// producer side is the write port, buffer is the storage array plus
// the occupancy tracker, consumer side is the read port.
// flags and level are registered; data and dvld follow a read by
// one cycle

module sync_fifo_top
   import fifo_pkg::*;
(
   input  logic   pos_clk,
   input  logic   aresetn,     // async, active low
   // producer
   input  logic   wr_en_i,
   input  data_t  wr_data_i,
   output logic   wack_o,
   output logic   overflow_o,
   // consumer
   input  logic   rd_en_i,
   output data_t  rd_data_o,
   output logic   dvld_o,
   output logic   underflow_o,
   // status
   output logic   full_o,
   output logic   afull_o,
   output logic   empty_o,
   output logic   aempty_o,
   output level_t level_o
);

   // -------------------------------------------------------------------------
   // internal wires
   // -------------------------------------------------------------------------
   logic  wr_acc;              // write port -> occupancy, ram
   logic  rd_acc;              // read port -> occupancy, ram
   addr_t wr_addr;
   addr_t rd_addr;

   // write port
   fifo_write_port u_wr_port (
      .pos_clk    (pos_clk),
      .aresetn    (aresetn),
      .wr_en_i    (wr_en_i),
      .full_i     (full_o),
      .wr_acc_o   (wr_acc),
      .wr_addr_o  (wr_addr),
      .wack_o     (wack_o),
      .overflow_o (overflow_o)
   );

   // occupancy counter and flags
   fifo_occupancy u_occ (
      .pos_clk  (pos_clk),
      .aresetn  (aresetn),
      .wr_acc_i (wr_acc),
      .rd_acc_i (rd_acc),
      .level_o  (level_o),
      .full_o   (full_o),
      .afull_o  (afull_o),
      .empty_o  (empty_o),
      .aempty_o (aempty_o)
   );

   // storage, no reset on the array
   fifo_ram u_ram (
      .pos_clk   (pos_clk),
      .wr_acc_i  (wr_acc),
      .wr_addr_i (wr_addr),
      .wr_data_i (wr_data_i),
      .rd_acc_i  (rd_acc),
      .rd_addr_i (rd_addr),
      .rd_data_o (rd_data_o)
   );

   // read port
   fifo_read_port u_rd_port (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .rd_en_i     (rd_en_i),
      .empty_i     (empty_o),
      .rd_acc_o    (rd_acc),
      .rd_addr_o   (rd_addr),
      .dvld_o      (dvld_o),
      .underflow_o (underflow_o)
   );

endmodule : sync_fifo_top

//--- src/fifo_read_port.sv
// fifo read port
// gates the read request with empty, steps the wrapping read address
// on each accepted read, and registers data-valid and the underflow
// error pulse

module fifo_read_port
   import fifo_pkg::*;
(
   input  logic  pos_clk,
   input  logic  aresetn,      // async, active low
   input  logic  rd_en_i,      // read request from consumer
   input  logic  empty_i,      // registered empty from occupancy
   output logic  rd_acc_o,     // accepted read, same cycle
   output addr_t rd_addr_o,    // array read address
   output logic  dvld_o,       // read data valid, one cycle later
   output logic  underflow_o   // read attempted while empty
);

   // -------------------------------------------------------------------------
   // internal state
   // -------------------------------------------------------------------------
   logic  rd_acc;
   addr_t rd_addr_q;
   logic  dvld_q;
   logic  underflow_q;

   // request passes only when something is stored
   assign rd_acc = rd_en_i & ~empty_i;

   // -------------------------------------------------------------------------
   // read address
   // -------------------------------------------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         rd_addr_q <= '0;
      end else if (rd_acc) begin
         if (rd_addr_q == addr_t'(FIFO_DEPTH - 1)) begin
            rd_addr_q <= '0;                   // wrap to entry 0
         end else begin
            rd_addr_q <= rd_addr_q + 1'b1;
         end
      end
   end

   // -------------------------------------------------------------------------
   // valid and error strobes
   // -------------------------------------------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         dvld_q      <= 1'b0;
         underflow_q <= 1'b0;
      end else begin
         dvld_q      <= rd_acc;                // aligned with ram output reg
         underflow_q <= rd_en_i & empty_i;     // dropped request
      end
   end

   // outputs
   assign rd_acc_o    = rd_acc;
   assign rd_addr_o   = rd_addr_q;
   assign dvld_o      = dvld_q;
   assign underflow_o = underflow_q;

endmodule : fifo_read_port

//--- src/fifo_ram.sv
// fifo storage array
// FIFO_DEPTH words of DATA_W bits. written on an accepted write,
// read into an output register on an accepted read, so the word
// shows up on the following cycle

module fifo_ram
   import fifo_pkg::*;
(
   input  logic  pos_clk,
   input  logic  wr_acc_i,     // accepted write
   input  addr_t wr_addr_i,
   input  data_t wr_data_i,
   input  logic  rd_acc_i,     // accepted read
   input  addr_t rd_addr_i,
   output data_t rd_data_o     // valid the cycle after rd_acc_i
);

   // -------------------------------------------------------------------------
   // storage
   // -------------------------------------------------------------------------
   data_t mem [FIFO_DEPTH];
   data_t rd_data_q;

   // write side
   always_ff @(posedge pos_clk) begin
      if (wr_acc_i) begin
         mem[wr_addr_i] <= wr_data_i;
      end
   end

   // read side, holds last word between reads
   always_ff @(posedge pos_clk) begin
      if (rd_acc_i) begin
         rd_data_q <= mem[rd_addr_i];
      end
   end

   assign rd_data_o = rd_data_q;

endmodule : fifo_ram

//--- src/fifo_occupancy.sv
// fifo occupancy tracker
// one counter holds the number of stored words. it moves only when
// exactly one of the accepted write and read pulses is high. the four
// status flags are registered from the next level, so they always
// agree with level_o in the same cycle

module fifo_occupancy
   import fifo_pkg::*;
(
   input  logic   pos_clk,
   input  logic   aresetn,     // async, active low
   input  logic   wr_acc_i,    // accepted write this cycle
   input  logic   rd_acc_i,    // accepted read this cycle
   output level_t level_o,     // words currently stored
   output logic   full_o,
   output logic   afull_o,
   output logic   empty_o,
   output logic   aempty_o
);

   // -------------------------------------------------------------------------
   // internal state
   // -------------------------------------------------------------------------
   level_t level_q;
   level_t level_d;
   logic   lvl_upd;            // exactly one side active
   logic   full_q;
   logic   afull_q;
   logic   empty_q;
   logic   aempty_q;

   // write and read together cancel out
   assign lvl_upd = wr_acc_i ^ rd_acc_i;

   // -------------------------------------------------------------------------
   // next level
   // -------------------------------------------------------------------------
   always_comb begin
      level_d = level_q;
      if (wr_acc_i && !rd_acc_i) begin
         level_d = level_q + 1'b1;             // write alone
      end else if (rd_acc_i && !wr_acc_i) begin
         level_d = level_q - 1'b1;             // read alone
      end
   end

   // -------------------------------------------------------------------------
   // counter
   // -------------------------------------------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         level_q <= '0;
      end else if (lvl_upd) begin
         level_q <= level_d;
      end
   end

   // -------------------------------------------------------------------------
   // status flags
   // -------------------------------------------------------------------------
   // taken from level_d so they line up with level_q next cycle
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         full_q   <= 1'b0;
         afull_q  <= 1'b0;
         empty_q  <= 1'b1;                     // starts empty
         aempty_q <= 1'b1;
      end else if (lvl_upd) begin
         full_q   <= (level_d == level_t'(FIFO_DEPTH));
         afull_q  <= (level_d >= level_t'(AFULL_LEVEL));
         empty_q  <= (level_d == '0);
         aempty_q <= (level_d <= level_t'(AEMPTY_LEVEL));
      end
   end

   // outputs
   assign level_o  = level_q;
   assign full_o   = full_q;
   assign afull_o  = afull_q;
   assign empty_o  = empty_q;
   assign aempty_o = aempty_q;

endmodule : fifo_occupancy

//--- src/fifo_write_port.sv
// fifo write port
// gates the write request with full, steps the wrapping write address
// on each accepted write, and registers the write acknowledge and the
// overflow error pulse

module fifo_write_port
   import fifo_pkg::*;
(
   input  logic  pos_clk,
   input  logic  aresetn,      // async, active low
   input  logic  wr_en_i,      // write request from producer
   input  logic  full_i,       // registered full from occupancy
   output logic  wr_acc_o,     // accepted write, same cycle
   output addr_t wr_addr_o,    // array write address
   output logic  wack_o,       // ack, one cycle after wr_acc_o
   output logic  overflow_o    // write attempted while full
);

   // -------------------------------------------------------------------------
   // internal state
   // -------------------------------------------------------------------------
   logic  wr_acc;
   addr_t wr_addr_q;
   logic  wack_q;
   logic  overflow_q;

   // request passes only when not full
   assign wr_acc = wr_en_i & ~full_i;

   // -------------------------------------------------------------------------
   // write address
   // -------------------------------------------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         wr_addr_q <= '0;
      end else if (wr_acc) begin
         if (wr_addr_q == addr_t'(FIFO_DEPTH - 1)) begin
            wr_addr_q <= '0;                   // wrap to entry 0
         end else begin
            wr_addr_q <= wr_addr_q + 1'b1;
         end
      end
   end

   // -------------------------------------------------------------------------
   // ack and error strobes
   // -------------------------------------------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         wack_q     <= 1'b0;
         overflow_q <= 1'b0;
      end else begin
         wack_q     <= wr_acc;                 // one pulse per stored word
         overflow_q <= wr_en_i & full_i;       // dropped request
      end
   end

   // outputs
   assign wr_acc_o   = wr_acc;
   assign wr_addr_o  = wr_addr_q;
   assign wack_o     = wack_q;
   assign overflow_o = overflow_q;

endmodule : fifo_write_port

//--- src/fifo_pkg.sv
// sync fifo shared definitions
// sizes, flag thresholds and the derived widths and types
// used by every block of the single-clock fifo

package fifo_pkg;

   // -------------------------------------------------------------------------
   // sizes
   // -------------------------------------------------------------------------
   localparam int FIFO_DEPTH = 16;               // entries in the array
   localparam int DATA_W     = 18;               // word width

   // derived widths
   localparam int ADDR_W  = $clog2(FIFO_DEPTH);  // 4 bits for 16 entries
   localparam int LEVEL_W = ADDR_W + 1;          // extra bit so 16 fits

   // -------------------------------------------------------------------------
   // static flag thresholds, in entries
   // -------------------------------------------------------------------------
   localparam int AFULL_LEVEL  = 12;             // afull at or above
   localparam int AEMPTY_LEVEL = 4;              // aempty at or below

   // -------------------------------------------------------------------------
   // types
   // -------------------------------------------------------------------------
   // array index, wraps after FIFO_DEPTH-1
   typedef logic [ADDR_W-1:0] addr_t;

   // fill level, 0 up to FIFO_DEPTH inclusive
   typedef logic [LEVEL_W-1:0] level_t;

   // one stored word
   typedef logic [DATA_W-1:0] data_t;

endpackage : fifo_pkg
